// ==== Makefile ====
# Verilator build and run of the whizGraphics testbench.

VERILATOR ?= verilator
TOP ?= whizGraphicsTb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/busDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module busDecoder
   import videoTypes::*;
(
   input  logic        db,
   input  logic        reset,
   input  logic [15:0] addr,
   input  logic        wrStrobe,
   input  logic        rdStrobe,
   output logic        vramWe,
   output logic        oamWe,
   output logic        regWe,
   output logic [12:0] cpuOffset,
   output logic [2:0]  regIndex,
   input  logic [7:0]  vramRdData,
   input  logic [7:0]  oamRdData,
   input  logic [7:0]  regRdData,
   output logic [7:0]  rdData,
   output logic        rdValid
);

   localparam int VRAM_END = int'(VRAM_BASE) + 2 ** VRAM_BITS;
   localparam int OAM_END = int'(OAM_BASE) + OAM_BYTES;
   localparam int REG_END = int'(REG_BASE) + REG_COUNT;

   logic vramSel;
   logic oamSel;
   logic regSel;
   logic vramHit;
   logic oamHit;
   logic regHit;

   // Region windows, end exclusive.
   assign vramSel = (int'(addr) >= int'(VRAM_BASE)) && (int'(addr) < VRAM_END);
   assign oamSel = (int'(addr) >= int'(OAM_BASE)) && (int'(addr) < OAM_END);
   assign regSel = (int'(addr) >= int'(REG_BASE)) && (int'(addr) < REG_END);

   assign vramWe = wrStrobe && vramSel;
   assign oamWe = wrStrobe && oamSel;
   assign regWe = wrStrobe && regSel;

   // Both memories take the low address bits.
   assign cpuOffset = addr[VRAM_BITS-1:0];
   assign regIndex = addr[2:0];

   // Remember where the read landed.
   always_ff @(posedge db) begin
      if (reset) begin
         rdValid <= 1'b0;
         vramHit <= 1'b0;
         oamHit <= 1'b0;
         regHit <= 1'b0;
      end else begin
         rdValid <= rdStrobe;
         vramHit <= rdStrobe && vramSel;
         oamHit <= rdStrobe && oamSel;
         regHit <= rdStrobe && regSel;
      end
   end

   // Every source is already registered, so the byte lines up with rdValid.
   always_comb begin
      if (vramHit) begin
         rdData = vramRdData;
      end else if (oamHit) begin
         rdData = oamRdData;
      end else if (regHit) begin
         rdData = regRdData;
      end else begin
         rdData = 8'hFF;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/lcdRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdRegisters
   import videoTypes::*;
(
   input  logic       db,
   input  logic       reset,
   input  logic       regWe,
   input  logic [2:0] regIndex,
   input  logic [7:0] wrData,
   output logic [7:0] regRdData,
   output logic       lcdOn,
   output logic       mapSelect,
   output logic [7:0] scrollY,
   output logic [7:0] scrollX,
   output logic [7:0] palette,
   input  logic [7:0] line,
   input  StatMode    mode
);

   logic [7:0] lcdc;
   logic [7:0] scy;
   logic [7:0] scx;
   logic [7:0] bgp;

   always_ff @(posedge db) begin
      if (reset) begin
         lcdc <= 8'h91;
         scy <= 8'h00;
         scx <= 8'h00;
         bgp <= 8'hFC;
      end else if (regWe) begin
         // STAT and LY are read-only here.
         case (regIndex)
            REG_LCDC: lcdc <= wrData;
            REG_SCY: scy <= wrData;
            REG_SCX: scx <= wrData;
            REG_BGP: bgp <= wrData;
            default: ;
         endcase
      end
   end

   // Registered like the memories, one cycle behind regIndex.
   always_ff @(posedge db) begin
      case (regIndex)
         REG_LCDC: regRdData <= lcdc;
         REG_STAT: regRdData <= {6'b100000, mode};
         REG_SCY: regRdData <= scy;
         REG_SCX: regRdData <= scx;
         REG_LY: regRdData <= line;
         REG_BGP: regRdData <= bgp;
         default: regRdData <= 8'hFF;
      endcase
   end

   assign lcdOn = lcdc[7];
   // Bit 3 picks the 9C00h map.
   assign mapSelect = lcdc[3];
   assign scrollY = scy;
   assign scrollX = scx;
   assign palette = bgp;

endmodule

`default_nettype wire

// ==== hdl/lineRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lineRenderer
   import videoTypes::*;
#(
   parameter int LINES = DEFAULT_LINES,
   parameter int WIDTH = DEFAULT_WIDTH
) (
   input  logic        db,
   input  logic        reset,
   input  logic        drawLine,
   input  logic        lcdOn,
   input  logic        mapSelect,
   input  logic [7:0]  scrollY,
   input  logic [7:0]  scrollX,
   input  logic [7:0]  palette,
   output logic [12:0] renderAddr,
   input  logic [7:0]  renderData,
   output logic        pixelValid,
   output logic [1:0]  pixel,
   output logic        lineDone,
   output logic        renderComplete,
   output logic [7:0]  line,
   output StatMode     mode
);

   localparam int PIX_BITS = $clog2(WIDTH + 1);

   typedef enum logic [2:0] {
      stIdle,
      stMap,
      stLow,
      stHigh,
      stLoad,
      stShift,
      stDone
   } RenderState;

   RenderState state;
   logic [PIX_BITS-1:0] pixCount;
   logic [4:0] xCol;
   logic [2:0] bitIdx;
   logic [7:0] tileIndex;
   logic [7:0] lowRow;
   logic [7:0] highRow;
   logic [7:0] yPos;
   logic [12:0] mapBase;
   logic [1:0] raw;
   logic lastLine;

   assign yPos = scrollY + line;
   assign mapBase = mapSelect ? MAP1_OFFSET : MAP0_OFFSET;
   assign lastLine = (line == 8'(LINES - 1));

   // Memory answers one cycle after the address, so each state reads
   // what the previous one asked for.
   always_comb begin
      case (state)
         stMap: renderAddr = mapBase + 13'({yPos[7:3], xCol});
         stLow: renderAddr = 13'(renderData * TILE_BYTES) + 13'({yPos[2:0], 1'b0});
         stHigh: renderAddr = 13'(tileIndex * TILE_BYTES) + 13'({yPos[2:0], 1'b1});
         default: renderAddr = mapBase;
      endcase
   end

   // Leftmost pixel sits in bit 7.
   assign raw = {highRow[~bitIdx], lowRow[~bitIdx]};
   assign pixel = palette[{raw, 1'b0} +: 2];
   assign pixelValid = (state == stShift);
   assign lineDone = (state == stDone);
   assign renderComplete = lineDone && lastLine;

   always_ff @(posedge db) begin
      if (reset) begin
         state <= stIdle;
         line <= 8'd0;
         mode <= modeVblank;
      end else begin
         case (state)
            stIdle: begin
               if (drawLine && lcdOn) begin
                  mode <= modeDrawing;
                  state <= stMap;
               end
            end
            stMap: state <= stLow;
            stLow: state <= stHigh;
            stHigh: state <= stLoad;
            stLoad: state <= stShift;
            stShift: begin
               if (pixCount == PIX_BITS'(WIDTH - 1)) begin
                  state <= stDone;
               end else if (bitIdx == 3'd7) begin
                  state <= stMap;
               end
            end
            stDone: begin
               state <= stIdle;
               if (lastLine) begin
                  line <= 8'd0;
                  mode <= modeVblank;
               end else begin
                  line <= line + 8'd1;
                  mode <= modeHblank;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // Column and pixel bookkeeping.
   always_ff @(posedge db) begin
      case (state)
         stIdle: begin
            // First column starts at the fine scroll.
            xCol <= scrollX[7:3];
            bitIdx <= scrollX[2:0];
            pixCount <= '0;
         end
         stLow: tileIndex <= renderData;
         stHigh: lowRow <= renderData;
         stLoad: highRow <= renderData;
         stShift: begin
            pixCount <= pixCount + 1'b1;
            bitIdx <= bitIdx + 3'd1;
            if (bitIdx == 3'd7) begin
               xCol <= xCol + 5'd1;
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/videoMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module videoMemory #(
   parameter int ADDR_BITS = 13
) (
   input  logic                 db,
   input  logic                 cpuWe,
   input  logic [ADDR_BITS-1:0] cpuAddr,
   input  logic [7:0]           cpuWrData,
   output logic [7:0]           cpuRdData,
   input  logic [ADDR_BITS-1:0] renderAddr,
   output logic [7:0]           renderData
);

   logic [7:0] mem [2 ** ADDR_BITS];

   // CPU port, read before write.
   always_ff @(posedge db) begin
      if (cpuWe) begin
         mem[cpuAddr] <= cpuWrData;
      end
      cpuRdData <= mem[cpuAddr];
   end

   // Renderer port.
   always_ff @(posedge db) begin
      renderData <= mem[renderAddr];
   end

endmodule

`default_nettype wire

// ==== hdl/videoTypes.sv ====
`default_nettype none

package videoTypes;

   // CPU address map.
   localparam logic [15:0] VRAM_BASE = 16'h8000;
   localparam int VRAM_BITS = 13;
   localparam logic [15:0] OAM_BASE = 16'hFE00;
   localparam int OAM_BYTES = 160;
   localparam int OAM_BITS = 8;
   localparam logic [15:0] REG_BASE = 16'hFF40;
   localparam int REG_COUNT = 8;

   // Register slots relative to REG_BASE.
   localparam logic [2:0] REG_LCDC = 3'd0;
   localparam logic [2:0] REG_STAT = 3'd1;
   localparam logic [2:0] REG_SCY = 3'd2;
   localparam logic [2:0] REG_SCX = 3'd3;
   localparam logic [2:0] REG_LY = 3'd4;
   localparam logic [2:0] REG_BGP = 3'd7;

   // Background maps, as VRAM offsets.
   localparam logic [12:0] MAP0_OFFSET = 13'h1800;
   localparam logic [12:0] MAP1_OFFSET = 13'h1C00;

   // Two bytes per tile row, eight rows.
   localparam int TILE_BYTES = 16;

   localparam int DEFAULT_LINES = 144;
   localparam int DEFAULT_WIDTH = 160;

   // Encoded as in the STAT register low bits.
   typedef enum logic [1:0] {
      modeHblank = 2'd0,
      modeVblank = 2'd1,
      modeDrawing = 2'd3
   } StatMode;

endpackage

`default_nettype wire

// ==== hdl/whizGraphics.sv ====
`timescale 1ns/1ps
`default_nettype none

module whizGraphics
   import videoTypes::*;
#(
   parameter int LINES = DEFAULT_LINES,
   parameter int WIDTH = DEFAULT_WIDTH
) (
   input  logic        db,
   input  logic        reset,
   input  logic [15:0] addr,
   input  logic [7:0]  wrData,
   input  logic        wrStrobe,
   input  logic        rdStrobe,
   output logic [7:0]  rdData,
   output logic        rdValid,
   input  logic        drawLine,
   output logic        pixelValid,
   output logic [1:0]  pixel,
   output logic        lineDone,
   output logic        renderComplete
);

   logic vramWe;
   logic oamWe;
   logic regWe;
   logic [12:0] cpuOffset;
   logic [2:0] regIndex;
   logic [7:0] vramRdData;
   logic [7:0] oamRdData;
   logic [7:0] regRdData;
   logic lcdOn;
   logic mapSelect;
   logic [7:0] scrollY;
   logic [7:0] scrollX;
   logic [7:0] palette;
   logic [12:0] renderAddr;
   logic [7:0] renderData;
   logic [7:0] line;
   StatMode mode;

   busDecoder u_busDecoder (
      .db(db),
      .reset(reset),
      .addr(addr),
      .wrStrobe(wrStrobe),
      .rdStrobe(rdStrobe),
      .vramWe(vramWe),
      .oamWe(oamWe),
      .regWe(regWe),
      .cpuOffset(cpuOffset),
      .regIndex(regIndex),
      .vramRdData(vramRdData),
      .oamRdData(oamRdData),
      .regRdData(regRdData),
      .rdData(rdData),
      .rdValid(rdValid)
   );

   videoMemory #(.ADDR_BITS(VRAM_BITS)) vramMem (
      .db(db),
      .cpuWe(vramWe),
      .cpuAddr(cpuOffset),
      .cpuWrData(wrData),
      .cpuRdData(vramRdData),
      .renderAddr(renderAddr),
      .renderData(renderData)
   );

   // OAM is CPU storage only.
   videoMemory #(.ADDR_BITS(OAM_BITS)) oamMem (
      .db(db),
      .cpuWe(oamWe),
      .cpuAddr(cpuOffset[OAM_BITS-1:0]),
      .cpuWrData(wrData),
      .cpuRdData(oamRdData),
      .renderAddr('0),
      .renderData()
   );

   lcdRegisters u_lcdRegisters (
      .db(db),
      .reset(reset),
      .regWe(regWe),
      .regIndex(regIndex),
      .wrData(wrData),
      .regRdData(regRdData),
      .lcdOn(lcdOn),
      .mapSelect(mapSelect),
      .scrollY(scrollY),
      .scrollX(scrollX),
      .palette(palette),
      .line(line),
      .mode(mode)
   );

   lineRenderer #(.LINES(LINES), .WIDTH(WIDTH)) u_lineRenderer (
      .db(db),
      .reset(reset),
      .drawLine(drawLine),
      .lcdOn(lcdOn),
      .mapSelect(mapSelect),
      .scrollY(scrollY),
      .scrollX(scrollX),
      .palette(palette),
      .renderAddr(renderAddr),
      .renderData(renderData),
      .pixelValid(pixelValid),
      .pixel(pixel),
      .lineDone(lineDone),
      .renderComplete(renderComplete),
      .line(line),
      .mode(mode)
   );

endmodule

`default_nettype wire

// ==== project.f ====
hdl/videoTypes.sv
hdl/busDecoder.sv
hdl/videoMemory.sv
hdl/lcdRegisters.sv
hdl/lineRenderer.sv
hdl/whizGraphics.sv
tests/whizGraphicsTb.sv

// ==== tests/whizGraphicsTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module whizGraphicsTb
   import videoTypes::*;
();

   localparam int LINES = 4;
   localparam int WIDTH = DEFAULT_WIDTH;
   localparam int FRAMES = 3;
   localparam int VRAM_SIZE = 2 ** VRAM_BITS;
   localparam int LINE_LIMIT = 400;
   localparam int FILL_CYCLES = 3 * (VRAM_SIZE + OAM_BYTES);
   localparam int WATCHDOG_CYCLES = FRAMES * LINES * LINE_LIMIT + FILL_CYCLES;

   logic db;
   logic reset;
   logic [15:0] addr;
   logic [7:0] wrData;
   logic wrStrobe;
   logic rdStrobe;
   logic [7:0] rdData;
   logic rdValid;
   logic drawLine;
   logic pixelValid;
   logic [1:0] pixel;
   logic lineDone;
   logic renderComplete;

   logic [7:0] vramShadow [VRAM_SIZE];
   logic [7:0] oamShadow [OAM_BYTES];
   logic [7:0] lcdcShadow;
   logic [7:0] scyShadow;
   logic [7:0] scxShadow;
   logic [7:0] bgpShadow;
   int modelLine;
   int errorCount;
   integer seed;

   whizGraphics #(.LINES(LINES), .WIDTH(WIDTH)) i_dut (
      .db(db),
      .reset(reset),
      .addr(addr),
      .wrData(wrData),
      .wrStrobe(wrStrobe),
      .rdStrobe(rdStrobe),
      .rdData(rdData),
      .rdValid(rdValid),
      .drawLine(drawLine),
      .pixelValid(pixelValid),
      .pixel(pixel),
      .lineDone(lineDone),
      .renderComplete(renderComplete)
   );

   always #10 db = ~db;

   initial begin
      #(WATCHDOG_CYCLES * 20);
      $display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic logic [15:0] regAddr(input logic [2:0] index);
      return REG_BASE + 16'(index);
   endfunction

   // Background pixel at index i of the current line.
   function automatic logic [1:0] expectedPixel(input int i);
      logic [7:0] x;
      logic [7:0] y;
      logic [7:0] tile;
      logic [7:0] lowRow;
      logic [7:0] highRow;
      int mapAddr;
      int rowAddr;
      int bitPos;
      int raw;
      x = 8'(int'(scxShadow) + i);
      y = 8'(int'(scyShadow) + modelLine);
      mapAddr = lcdcShadow[3] ? int'(MAP1_OFFSET) : int'(MAP0_OFFSET);
      mapAddr = mapAddr + (int'(y) / 8) * 32 + int'(x) / 8;
      tile = vramShadow[mapAddr];
      rowAddr = int'(tile) * TILE_BYTES + (int'(y) % 8) * 2;
      lowRow = vramShadow[rowAddr];
      highRow = vramShadow[rowAddr + 1];
      bitPos = 7 - int'(x) % 8;
      raw = 2 * int'(highRow[bitPos]) + int'(lowRow[bitPos]);
      return bgpShadow[raw * 2 +: 2];
   endfunction

   task automatic checkValue(input string name, input int expected, input int actual);
      assert (expected == actual) else begin
         errorCount++;
         $display("Fail at %0d ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      end
   endtask

   task automatic busWrite(input logic [15:0] a, input logic [7:0] d);
      @(posedge db);
      addr <= a;
      wrData <= d;
      wrStrobe <= 1'b1;
      @(posedge db);
      wrStrobe <= 1'b0;
   endtask

   // rdValid must be up for exactly the one cycle after the strobe.
   task automatic busRead(input logic [15:0] a, output logic [7:0] value);
      @(posedge db);
      addr <= a;
      rdStrobe <= 1'b1;
      @(posedge db);
      rdStrobe <= 1'b0;
      @(negedge db);
      checkValue("rdValid", 1, int'(rdValid));
      value = rdData;
      @(negedge db);
      checkValue("rdValid", 0, int'(rdValid));
   endtask

   task automatic readExpect(input logic [15:0] a, input logic [7:0] expected,
                             input string name);
      logic [7:0] value;
      busRead(a, value);
      checkValue(name, int'(expected), int'(value));
   endtask

   task automatic readMode(input StatMode expected);
      logic [7:0] value;
      busRead(regAddr(REG_STAT), value);
      checkValue("STAT mode", int'(expected), int'(value[1:0]));
   endtask

   task automatic drawAndCheck();
      int count;
      int cycles;
      logic finished;
      count = 0;
      cycles = 0;
      finished = 1'b0;
      @(posedge db);
      drawLine <= 1'b1;
      @(posedge db);
      drawLine <= 1'b0;
      while (!finished && cycles < LINE_LIMIT) begin
         @(negedge db);
         cycles++;
         if (pixelValid) begin
            checkValue("pixel", int'(expectedPixel(count)), int'(pixel));
            count++;
         end
         if (lineDone) begin
            finished = 1'b1;
            checkValue("renderComplete", int'(modelLine == LINES - 1), int'(renderComplete));
         end else begin
            checkValue("renderComplete", 0, int'(renderComplete));
         end
      end
      assert (finished) else begin
         errorCount++;
         $display("Line %0d did not finish within %0d cycles", modelLine, LINE_LIMIT);
      end
      assert (count == WIDTH) else begin
         errorCount++;
         $display("Line %0d produced %0d pixels instead of %0d", modelLine, count, WIDTH);
      end
      modelLine = (modelLine + 1) % LINES;
      readExpect(regAddr(REG_LY), 8'(modelLine), "LY");
      readMode((modelLine == 0) ? modeVblank : modeHblank);
   endtask

   task automatic setupFrame(input logic [7:0] lcdc, input logic [7:0] scy,
                             input logic [7:0] scx, input logic [7:0] bgp);
      lcdcShadow = lcdc;
      scyShadow = scy;
      scxShadow = scx;
      bgpShadow = bgp;
      busWrite(regAddr(REG_LCDC), lcdc);
      busWrite(regAddr(REG_SCY), scy);
      busWrite(regAddr(REG_SCX), scx);
      busWrite(regAddr(REG_BGP), bgp);
   endtask

   initial begin
      logic [7:0] value;
      logic [7:0] scy;
      logic [7:0] scx;
      int a;
      int activity;
      db = 1'b0;
      reset = 1'b1;
      addr = 16'h0000;
      wrData = 8'h00;
      wrStrobe = 1'b0;
      rdStrobe = 1'b0;
      drawLine = 1'b0;
      errorCount = 0;
      modelLine = 0;
      seed = 32'h0b8983f6;
      repeat (8) @(posedge db);
      reset <= 1'b0;

      readExpect(regAddr(REG_LCDC), 8'h91, "LCDC");
      readExpect(regAddr(REG_BGP), 8'hFC, "BGP");
      readExpect(regAddr(REG_LY), 8'h00, "LY");
      readMode(modeVblank);

      // Random fill of both memories.
      for (a = 0; a < VRAM_SIZE; a++) begin
         vramShadow[a] = 8'($random(seed));
         busWrite(16'(int'(VRAM_BASE) + a), vramShadow[a]);
      end
      for (a = 0; a < OAM_BYTES; a++) begin
         oamShadow[a] = 8'($random(seed));
         busWrite(16'(int'(OAM_BASE) + a), oamShadow[a]);
      end
      repeat (64) begin
         a = $random(seed) & (VRAM_SIZE - 1);
         readExpect(16'(int'(VRAM_BASE) + a), vramShadow[a], "VRAM rdData");
      end
      for (a = 0; a < OAM_BYTES; a++) begin
         readExpect(16'(int'(OAM_BASE) + a), oamShadow[a], "OAM rdData");
      end

      // Register round trip.
      value = 8'($random(seed));
      busWrite(regAddr(REG_SCY), value);
      readExpect(regAddr(REG_SCY), value, "SCY");
      value = 8'($random(seed));
      busWrite(regAddr(REG_SCX), value);
      readExpect(regAddr(REG_SCX), value, "SCX");
      value = 8'($random(seed));
      busWrite(regAddr(REG_BGP), value);
      readExpect(regAddr(REG_BGP), value, "BGP");

      // Holes in the map.
      readExpect(16'h0000, 8'hFF, "unmapped rdData");
      readExpect(16'hA000, 8'hFF, "unmapped rdData");
      readExpect(16'(int'(OAM_BASE) + OAM_BYTES), 8'hFF, "unmapped rdData");
      readExpect(regAddr(3'd5), 8'hFF, "unused register");
      readExpect(16'(int'(REG_BASE) + REG_COUNT), 8'hFF, "unmapped rdData");

      for (int frame = 0; frame < FRAMES; frame++) begin
         if (frame == 0) begin
            setupFrame(8'h91, 8'h00, 8'h00, 8'hE4);
         end else begin
            scy = 8'($random(seed));
            scx = 8'($random(seed));
            if (scy == 8'h00) scy = 8'h01;
            if (scx == 8'h00) scx = 8'h01;
            // Second map with wrapped scroll.
            setupFrame(8'h99, scy, scx, 8'($random(seed)));
         end
         repeat (LINES) drawAndCheck();
      end

      // Display off.
      lcdcShadow = 8'h11;
      busWrite(regAddr(REG_LCDC), lcdcShadow);
      activity = 0;
      @(posedge db);
      drawLine <= 1'b1;
      @(posedge db);
      drawLine <= 1'b0;
      repeat (50) begin
         @(negedge db);
         if (pixelValid || lineDone) activity++;
      end
      assert (activity == 0) else begin
         errorCount++;
         $display("drawLine with the display off still produced pixels or lineDone");
      end
      readExpect(regAddr(REG_LY), 8'h00, "LY");
      readMode(modeVblank);

      $display("Errors: %0d", errorCount);
      if (errorCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
